// File: verilog.f
cache_pkg.sv
way_if.sv
cache_array.sv
cache_way.sv
cache_ctrl.sv
l1_dcache.sv
tb_l1_dcache.sv

// File: tb_l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1_dcache
    import cache_pkg::*;
();

    localparam time DRIVE_DELAY  = 1ns;
    localparam int  RESET_CYCLES = 5;
    localparam int  NUM_DIRECTED = 14;
    localparam int  NUM_RANDOM   = 200;
    // worst read miss takes accept, lookup, four beats with two gaps each, done and idle
    localparam int  WORST_CYCLES = 16;
    localparam int  CYCLE_LIMIT  =
        4 * (NUM_DIRECTED + NUM_RANDOM) * WORST_CYCLES + 4 * RESET_CYCLES;

    logic  clk = 1'b0;
    logic  rst;
    logic  core_req;
    logic  core_write;
    word_t core_addr;
    word_t core_wdata;
    word_t core_rdata;
    logic  core_ready;
    logic  core_wait;
    word_t mem_rdata;
    logic  mem_ready;
    logic  mem_req;
    word_t mem_addr;

    // reference model of tags, valid bits, lru and line contents
    logic [22:0] m_tag   [NUM_WAYS][NUM_SETS];
    bit          m_valid [NUM_WAYS][NUM_SETS];
    bit          m_lru   [NUM_SETS];
    word_t       m_data  [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];

    logic [31:0] lcg_state = 32'd70;
    int          cycle_cnt = 0;

    l1_dcache l1_dcache_inst (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .core_write (core_write),
        .core_addr  (core_addr),
        .core_wdata (core_wdata),
        .core_rdata (core_rdata),
        .core_ready (core_ready),
        .core_wait  (core_wait),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr)
    );

    always #50ns clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: no finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    function automatic word_t rand_word();
        return {16'(next_rand()), 16'(next_rand())};
    endfunction

    // memory word as a fixed function of its address
    function automatic word_t memory_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h3c6e_f372;
    endfunction

    // tag in bits 31:9 with index 8:4 and word 3:2
    function automatic word_t make_addr(input int tag, input int set, input int word);
        return {23'(tag), 5'(set), 2'(word), 2'b00};
    endfunction

    function automatic bit find_hit_way(input word_t addr, output int way);
        way = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[w][addr[8:4]] && m_tag[w][addr[8:4]] == addr[31:9]) begin
                way = w;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // m_lru holds the way touched last
    function automatic int pick_victim(input int set);
        if (!m_valid[0][set]) begin
            return 0;
        end else if (!m_valid[1][set]) begin
            return 1;
        end
        return m_lru[set] ? 0 : 1;
    endfunction

    task automatic check_quiet(input string when);
        assert (core_ready === 1'b0 && core_wait === 1'b0 && mem_req === 1'b0)
        else abort_run($sformatf("mismatch at %0t: outputs not low %s", $time, when));
    endtask

    task automatic run_request(input logic wr, input word_t addr, input word_t wdata);
        int    hit_way;
        bit    hit;
        bit    exp_miss;
        int    fill_way;
        int    set;
        int    word;
        word_t exp_rdata;
        word_t line_addr;
        int    cyc;
        int    beats;
        int    gap_left;
        int    ready_cnt;
        int    last_beat_cyc;
        int    exp_idle_cyc;
        bit    beat_now;
        bit    exp_mem_req;
        bit    done;
        set       = addr[8:4];
        word      = addr[3:2];
        line_addr = {addr[31:4], 4'h0};
        hit       = find_hit_way(addr, hit_way);
        exp_miss  = !wr && !hit;
        fill_way  = pick_victim(set);
        exp_rdata = hit ? m_data[hit_way][set][word] : memory_word(addr);
        core_req   = 1'b1;
        core_write = wr;
        core_addr  = addr;
        core_wdata = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        core_req   = 1'b0;
        core_write = 1'b0;
        cyc           = 1;
        beats         = 0;
        gap_left      = next_rand() % 3;
        ready_cnt     = 0;
        last_beat_cyc = 0;
        done          = 1'b0;
        while (!done) begin
            beat_now  = 1'b0;
            mem_ready = 1'b0;
            mem_rdata = '0;
            // beats start the cycle after lookup with random gaps
            if (exp_miss && cyc > 1 && beats < WORDS_PER_LINE) begin
                if (gap_left > 0) begin
                    gap_left--;
                end else begin
                    mem_ready     = 1'b1;
                    mem_rdata     = memory_word(line_addr + 32'(4 * beats));
                    beats++;
                    beat_now      = 1'b1;
                    last_beat_cyc = cyc;
                    gap_left      = next_rand() % 3;
                end
            end
            @(negedge clk);
            exp_mem_req = exp_miss && (beats < WORDS_PER_LINE || beat_now);
            assert (mem_req === exp_mem_req)
            else abort_run($sformatf("mismatch at %0t: mem_req %b, expected %b for %h",
                                     $time, mem_req, exp_mem_req, addr));
            if (mem_req === 1'b1) begin
                assert (mem_addr === line_addr)
                else abort_run($sformatf("mismatch at %0t: mem_addr %h, expected %h",
                                         $time, mem_addr, line_addr));
            end
            if (core_ready === 1'b1) begin
                ready_cnt++;
                if (exp_miss) begin
                    assert (beat_now && beats - 1 == word)
                    else abort_run("core_ready came outside the beat of the requested word");
                end else begin
                    assert (cyc == ((wr && hit) ? 2 : 1))
                    else abort_run($sformatf("core_ready came in cycle %0d after accept", cyc));
                end
                if (!wr) begin
                    assert (core_rdata === exp_rdata)
                    else abort_run($sformatf("mismatch at %0t: core_rdata %h, expected %h",
                                             $time, core_rdata, exp_rdata));
                end
            end else begin
                assert (core_rdata === '0)
                else abort_run($sformatf("mismatch at %0t: core_rdata %h outside core_ready",
                                         $time, core_rdata));
            end
            if (core_wait !== 1'b1) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
                #DRIVE_DELAY;
                cyc++;
            end
        end
        exp_idle_cyc = exp_miss ? last_beat_cyc + 2 : ((wr && hit) ? 3 : 2);
        assert (ready_cnt == 1)
        else abort_run($sformatf("core_ready pulsed %0d times instead of once", ready_cnt));
        assert (!exp_miss || beats == WORDS_PER_LINE)
        else abort_run($sformatf("refill ended after %0d beats", beats));
        assert (cyc == exp_idle_cyc)
        else abort_run($sformatf("mismatch at %0t: idle in cycle %0d, expected %0d",
                                 $time, cyc, exp_idle_cyc));
        // model update
        if (hit) begin
            m_lru[set] = hit_way[0];
            if (wr) begin
                m_data[hit_way][set][word] = wdata;
            end
        end else if (!wr) begin
            m_tag[fill_way][set]   = addr[31:9];
            m_valid[fill_way][set] = 1'b1;
            m_lru[set]             = fill_way[0];
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                m_data[fill_way][set][w] = memory_word(line_addr + 32'(4 * w));
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    initial begin
        int    r;
        bit    wr;
        word_t addr;
        rst        = 1'b1;
        core_req   = 1'b0;
        core_write = 1'b0;
        core_addr  = '0;
        core_wdata = '0;
        mem_rdata  = '0;
        mem_ready  = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        check_quiet("in reset");
        rst = 1'b0;
        @(negedge clk);
        check_quiet("after reset");
        @(posedge clk);
        #DRIVE_DELAY;

        // first read misses and the next two hit the same line
        run_request(1'b0, make_addr('h123, 5, 2), '0);
        run_request(1'b0, make_addr('h123, 5, 2), '0);
        run_request(1'b0, make_addr('h123, 5, 0), '0);
        // write hit then read back
        run_request(1'b1, make_addr('h123, 5, 1), 32'hdead_beef);
        run_request(1'b0, make_addr('h123, 5, 1), '0);
        // write miss leaves no line behind
        run_request(1'b1, make_addr('h456, 6, 3), 32'h1234_5678);
        run_request(1'b0, make_addr('h456, 6, 3), '0);

        // three lines share set 9 so lru picks each victim
        run_request(1'b0, make_addr('h10, 9, 0), '0);
        run_request(1'b0, make_addr('h20, 9, 1), '0);
        run_request(1'b0, make_addr('h10, 9, 2), '0);
        run_request(1'b0, make_addr('h30, 9, 3), '0);
        run_request(1'b0, make_addr('h20, 9, 1), '0);
        run_request(1'b0, make_addr('h30, 9, 0), '0);
        run_request(1'b0, make_addr('h10, 9, 2), '0);

        // random mix over three tags and four sets
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r    = next_rand();
            wr   = ((r / 48) % 4) == 0;
            addr = make_addr('h1a00 + r % 3, ((r / 3) % 4) * 7 + 2, (r / 12) % 4);
            run_request(wr, addr, rand_word());
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_dcache
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // core side
    input  logic              core_req,
    input  logic              core_write,
    input  logic [ADDR_W-1:0] core_addr,
    input  logic [ADDR_W-1:0] core_wdata,
    output logic [ADDR_W-1:0] core_rdata,
    output logic              core_ready,
    output logic              core_wait,

    // memory side
    input  logic [ADDR_W-1:0] mem_rdata,
    input  logic              mem_ready,
    output logic              mem_req,
    output logic [ADDR_W-1:0] mem_addr
);

    // one bus per way
    way_if way_bus [NUM_WAYS] ();

    cache_ctrl ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .core_write (core_write),
        .core_addr  (core_addr),
        .core_wdata (core_wdata),
        .core_rdata (core_rdata),
        .core_ready (core_ready),
        .core_wait  (core_wait),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .way0       (way_bus[0]),
        .way1       (way_bus[1])
    );

    // both ways look up in parallel
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way way_inst (
            .clk (clk),
            .rst (rst),
            .bus (way_bus[w])
        );
    end

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              core_req,
    input  logic              core_write,
    input  word_t             core_addr,
    input  word_t             core_wdata,
    output word_t             core_rdata,
    output logic              core_ready,
    output logic              core_wait,
    input  word_t             mem_rdata,
    input  logic              mem_ready,
    output logic              mem_req,
    output word_t             mem_addr,
    way_if.ctrl               way0,
    way_if.ctrl               way1
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL,
        ST_WRITE,
        ST_DONE
    } state_t;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_sel_t;

    state_t              state;
    state_t              state_nx;
    word_t               addr_q;
    logic                write_q;
    word_t               wdata_q;
    way_sel_t            tgt_way_q;
    way_sel_t            victim;
    word_sel_t           beat_q;
    logic [NUM_SETS-1:0] lru_q;

    index_t              idx_q;
    tag_t                tag_q;
    word_sel_t           wsel_q;
    logic                hit0;
    logic                hit1;
    logic                hit;
    word_t               hit_rdata;
    logic                accept;
    logic                fill_beat;
    logic                last_beat;
    logic                word_wr;
    logic                tag_wr;
    index_t              index;
    word_sel_t           word_sel;
    word_t               wdata;

    assign accept = (state == ST_IDLE) && core_req;

    assign idx_q  = addr_index(addr_q);
    assign tag_q  = addr_tag(addr_q);
    assign wsel_q = addr_word(addr_q);

    // hit combining across the two ways
    assign hit0      = way0.hit;
    assign hit1      = way1.hit;
    assign hit       = hit0 || hit1;
    assign hit_rdata = hit1 ? way1.rdata : way0.rdata;

    assign fill_beat = (state == ST_REFILL) && mem_ready;
    assign last_beat = fill_beat && (beat_q == WORD_SEL_W'(WORDS_PER_LINE - 1));

    // invalid ways first, then the least recently used one
    always_comb begin
        if (!way0.valid) begin
            victim = way_sel_t'(0);
        end else if (!way1.valid) begin
            victim = way_sel_t'(1);
        end else begin
            victim = way_sel_t'(~lru_q[idx_q]);
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE: begin
                if (core_req) begin
                    state_nx = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (write_q) begin
                    state_nx = hit ? ST_WRITE : ST_IDLE;
                end else begin
                    state_nx = hit ? ST_IDLE : ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (last_beat) begin
                    state_nx = ST_DONE;
                end
            end
            ST_WRITE: begin
                state_nx = ST_IDLE;
            end
            ST_DONE: begin
                state_nx = ST_IDLE;
            end
            default: begin
                state_nx = ST_IDLE;
            end
        endcase
    end

    // core side completion and read data
    always_comb begin
        core_ready = 1'b0;
        core_rdata = '0;
        case (state)
            ST_LOOKUP: begin
                if (write_q && !hit) begin
                    core_ready = 1'b1;
                end else if (!write_q && hit) begin
                    core_ready = 1'b1;
                    core_rdata = hit_rdata;
                end
            end
            ST_REFILL: begin
                // forward the requested word as its beat arrives
                if (fill_beat && beat_q == wsel_q) begin
                    core_ready = 1'b1;
                    core_rdata = mem_rdata;
                end
            end
            ST_WRITE: begin
                core_ready = 1'b1;
            end
            default: begin
                core_ready = 1'b0;
            end
        endcase
    end

    assign core_wait = (state != ST_IDLE);

    assign mem_req  = ((state == ST_LOOKUP) && !write_q && !hit) || (state == ST_REFILL);
    assign mem_addr = mem_req ? {addr_q[ADDR_W-1:LINE_OFFSET_W], LINE_OFFSET_W'(0)} : '0;

    // array reads are registered, so idle presents the incoming index
    assign index    = (state == ST_IDLE) ? addr_index(core_addr) : idx_q;
    assign word_sel = (state == ST_REFILL) ? beat_q : wsel_q;
    assign wdata    = (state == ST_REFILL) ? mem_rdata : wdata_q;
    assign word_wr  = fill_beat || (state == ST_WRITE);
    assign tag_wr   = last_beat;

    assign way0.index    = index;
    assign way0.rd_en    = accept;
    assign way0.word_sel = word_sel;
    assign way0.wdata    = wdata;
    assign way0.wtag     = tag_q;
    assign way0.word_wr  = word_wr && (tgt_way_q == way_sel_t'(0));
    assign way0.tag_wr   = tag_wr && (tgt_way_q == way_sel_t'(0));

    assign way1.index    = index;
    assign way1.rd_en    = accept;
    assign way1.word_sel = word_sel;
    assign way1.wdata    = wdata;
    assign way1.wtag     = tag_q;
    assign way1.word_wr  = word_wr && (tgt_way_q == way_sel_t'(1));
    assign way1.tag_wr   = tag_wr && (tgt_way_q == way_sel_t'(1));

    // request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= core_addr;
            write_q <= core_write;
            wdata_q <= core_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            tgt_way_q <= '0;
            beat_q    <= '0;
            lru_q     <= '0;
        end else begin
            state <= state_nx;
            if (state == ST_LOOKUP) begin
                beat_q <= '0;
                // hit way for a write, victim for a refill
                tgt_way_q <= hit ? way_sel_t'(hit1) : victim;
                if (hit) begin
                    lru_q[idx_q] <= hit1;
                end
            end
            if (fill_beat) begin
                beat_q <= beat_q + 1'b1;
            end
            if (last_beat) begin
                lru_q[idx_q] <= tgt_way_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way
    import cache_pkg::*;
(
    input logic clk,
    input logic rst,
    way_if.way  bus
);

    logic [NUM_SETS-1:0]       valid_bits;
    tag_t                      tag_rd;
    line_t                     line_rd;
    line_t                     line_wr;
    logic [WORDS_PER_LINE-1:0] lane_mask;

    // tag store, one lane wide so the mask is a single bit
    cache_array #(
        .entry_t (tag_t),
        .DEPTH   (NUM_SETS)
    ) tag_store_inst (
        .clk   (clk),
        .index (bus.index),
        .rd_en (bus.rd_en),
        .wr_en (bus.tag_wr),
        .wmask (1'b1),
        .wdata (bus.wtag),
        .rdata (tag_rd)
    );

    cache_array #(
        .entry_t (line_t),
        .DEPTH   (NUM_SETS)
    ) data_store_inst (
        .clk   (clk),
        .index (bus.index),
        .rd_en (bus.rd_en),
        .wr_en (bus.word_wr),
        .wmask (lane_mask),
        .wdata (line_wr),
        .rdata (line_rd)
    );

    // put the write word in its lane and enable only that lane
    always_comb begin
        line_wr = '0;
        line_wr[bus.word_sel] = bus.wdata;
        lane_mask = '0;
        lane_mask[bus.word_sel] = 1'b1;
    end

    // valid bit is set together with the tag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (bus.tag_wr) begin
            valid_bits[bus.index] <= 1'b1;
        end
    end

    assign bus.valid = valid_bits[bus.index];

    // wtag carries the lookup tag during the compare
    assign bus.hit = bus.valid && (tag_rd == bus.wtag);

    assign bus.rdata = line_rd[bus.word_sel];

endmodule

`default_nettype wire

// File: cache_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_array
    import cache_pkg::*;
#(
    parameter type entry_t = word_t,
    parameter int  DEPTH   = NUM_SETS
) (
    input  logic                                 clk,
    input  index_t                               index,
    input  logic                                 rd_en,
    input  logic                                 wr_en,
    input  logic [lanes_of($bits(entry_t))-1:0]  wmask,
    input  entry_t                               wdata,
    output entry_t                               rdata
);

    entry_t                    mem [DEPTH];
    logic [$bits(entry_t)-1:0] bit_mask;

    // each bit follows the enable of its word lane
    always_comb begin
        for (int b = 0; b < $bits(entry_t); b++) begin
            bit_mask[b] = wmask[b / $bits(word_t)];
        end
    end

    // single port with lane-masked write and registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index] <= (mem[index] & ~bit_mask) | (wdata & bit_mask);
        end
        // output holds its last value while rd_en is low
        if (rd_en) begin
            rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

// File: way_if.sv
`timescale 1ns/1ps
`default_nettype none

interface way_if
    import cache_pkg::*;
();

    // driven by the controller
    index_t    index;
    logic      rd_en;
    logic      tag_wr;
    logic      word_wr;
    word_sel_t word_sel;
    word_t     wdata;
    tag_t      wtag;

    // driven by the way
    logic      hit;
    logic      valid;
    word_t     rdata;

    modport ctrl (
        output index, rd_en, tag_wr, word_wr, word_sel, wdata, wtag,
        input  hit, valid, rdata
    );

    modport way (
        input  index, rd_en, tag_wr, word_wr, word_sel, wdata, wtag,
        output hit, valid, rdata
    );

endinterface

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    // address and data word width
    localparam int ADDR_W = 32;

    // set geometry, index from address bits 8:4
    localparam int NUM_SETS  = 32;
    localparam int INDEX_W   = 5;
    localparam int INDEX_LSB = 4;

    // word select from address bits 3:2
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_SEL_W     = 2;
    localparam int WORD_SEL_LSB   = 2;

    // tag from address bits 31:9
    localparam int TAG_W   = 23;
    localparam int TAG_LSB = 9;

    // byte offset bits inside one line
    localparam int LINE_OFFSET_W = 4;

    localparam int NUM_WAYS = 2;

    typedef logic [ADDR_W-1:0]         word_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [WORD_SEL_W-1:0]     word_sel_t;

    // number of word lanes needed to cover an entry of the given width
    function automatic int lanes_of(input int bits);
        return (bits + ADDR_W - 1) / ADDR_W;
    endfunction

    function automatic index_t addr_index(input word_t addr);
        return addr[INDEX_LSB +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(input word_t addr);
        return addr[TAG_LSB +: TAG_W];
    endfunction

    function automatic word_sel_t addr_word(input word_t addr);
        return addr[WORD_SEL_LSB +: WORD_SEL_W];
    endfunction

endpackage

`default_nettype wire
